//--- Bender.yml
package:
  name: avmm_mux

sources:
  - verilog/avmm_bus_pkg.sv
  - verilog/avmm_mux_pkg.sv
  - verilog/avmm_cmd_fifo.sv
  - verilog/avmm_rr_arbiter.sv
  - verilog/avmm_rsp_router.sv
  - verilog/avmm_mem_model.sv
  - verilog/avmm_mux_top.sv
  - target: test
    files:
      - tb/avmm_mux_checker.sv
      - tb/avmm_mux_tb.sv

//--- list.f
verilog/avmm_bus_pkg.sv
verilog/avmm_mux_pkg.sv
verilog/avmm_cmd_fifo.sv
verilog/avmm_rr_arbiter.sv
verilog/avmm_rsp_router.sv
verilog/avmm_mem_model.sv
verilog/avmm_mux_top.sv
tb/avmm_mux_checker.sv
tb/avmm_mux_tb.sv

//--- tb/avmm_mux_checker.sv
/*
 * Scoreboard beside the DUT. Each port must stay inside its own 16-word
 * window, so per-port command order alone fixes every read value.
 * Counters change on the rising edge and are stable at the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_mux_checker
    import avmm_bus_pkg::*;
    import avmm_mux_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [NUM_PORTS-1:0] req_valid,
    input  avmm_req_t            req [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] waitrequest,
    input  logic [NUM_PORTS-1:0] rsp_valid,
    input  avmm_rsp_t            rsp [NUM_PORTS],
    input  logic                 fair_en,
    output int                   errors,
    output int                   checked,
    output int                   pending,
    output int                   accepted,
    output int                   completed
);

    // Model memory, updated in acceptance order
    data_t     ref_mem  [MEM_WORDS];
    // Expected response beats, one queue per port
    avmm_rsp_t exp_q    [NUM_PORTS][$];
    int        done_cnt [NUM_PORTS];
    // Completion counts when the fairness window opened
    int        base_cnt [NUM_PORTS];

    // Reference model of a byte-enabled write into a stored word
    function automatic data_t merge_write(data_t old, data_t wdata, byte_en_t be);
        data_t w;
        w = old;
        for (int b = 0; b < $bits(byte_en_t); b++)
        begin
            if (be[b])
                w[8*b +: 8] = wdata[8*b +: 8];
        end
        return w;
    endfunction

    // Expected beats of one accepted command
    task automatic predict(input int p, input avmm_req_t c);
        avmm_rsp_t e;
        if (c.op == OP_WRITE)
        begin
            ref_mem[c.addr] = merge_write(ref_mem[c.addr], c.writedata, c.byteenable);
            e.op       = OP_WRITE;
            e.readdata = '0;
            e.last     = 1'b1;
            exp_q[p].push_back(e);
        end
        else
        begin
            for (int k = 0; k < int'(c.burstcount); k++)
            begin
                e.op       = OP_READ;
                e.readdata = ref_mem[addr_t'(int'(c.addr) + k)];
                e.last     = (k == int'(c.burstcount) - 1);
                exp_q[p].push_back(e);
            end
        end
    endtask

    // No port may run more than one command ahead of another
    task automatic check_fair(input int p);
        for (int q = 0; q < NUM_PORTS; q++)
        begin
            if ((done_cnt[p] - base_cnt[p]) > (done_cnt[q] - base_cnt[q]) + 1)
            begin
                errors++;
                $display("Port %0d finished %0d commands while port %0d finished only %0d at %0t",
                         p, done_cnt[p] - base_cnt[p], q, done_cnt[q] - base_cnt[q], $time);
            end
        end
    endtask

    task automatic compare_rsp(input int p);
        avmm_rsp_t e;
        if (exp_q[p].size() == 0)
        begin
            errors++;
            $display("Port %0d gave a response at %0t with no command outstanding", p, $time);
        end
        else
        begin
            e = exp_q[p].pop_front();
            checked++;
            if (rsp[p].op !== e.op)
            begin
                errors++;
                $display("ERROR t=%0t rsp[%0d].op expected %0d actual %0d",
                         $time, p, e.op, rsp[p].op);
            end
            if (rsp[p].last !== e.last)
            begin
                errors++;
                $display("ERROR t=%0t rsp[%0d].last expected %0b actual %0b",
                         $time, p, e.last, rsp[p].last);
            end
            // Write responses carry no data worth checking
            if (e.op == OP_READ && rsp[p].readdata !== e.readdata)
            begin
                errors++;
                $display("ERROR t=%0t rsp[%0d].readdata expected %08h actual %08h",
                         $time, p, e.readdata, rsp[p].readdata);
            end
            if (e.last)
            begin
                done_cnt[p]++;
                if (fair_en)
                    check_fair(p);
            end
        end
    endtask

    // ==================================================
    // Watch the ports on every rising edge
    // ==================================================

    always @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            // The memory reads as zero after reset
            foreach (ref_mem[i])
                ref_mem[i] = '0;
            for (int p = 0; p < NUM_PORTS; p++)
                exp_q[p].delete();
            pending = 0;
        end
        else
        begin
            if (!fair_en)
                base_cnt = done_cnt;
            for (int p = 0; p < NUM_PORTS; p++)
            begin
                if (req_valid[p] && !waitrequest[p])
                begin
                    accepted++;
                    predict(p, req[p]);
                end
                if (rsp_valid[p])
                begin
                    // Completions follow the last flags that the DUT itself sends
                    if (rsp[p].last)
                        completed++;
                    compare_rsp(p);
                end
            end
            pending = 0;
            for (int p = 0; p < NUM_PORTS; p++)
                pending += exp_q[p].size();
        end
    end

endmodule

`default_nettype wire

//--- tb/avmm_mux_tb.sv
/*
 * Testbench for the port multiplexer. Port p keeps to words 16p to 16p+15.
 * A wait that runs out of cycles ends the run at once.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_mux_tb
    import avmm_bus_pkg::*;
    import avmm_mux_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 400;

    logic                 clk;
    logic                 arst_n;
    logic [NUM_PORTS-1:0] req_valid;
    avmm_req_t            req [NUM_PORTS];
    logic [NUM_PORTS-1:0] waitrequest;
    logic [NUM_PORTS-1:0] rsp_valid;
    avmm_rsp_t            rsp [NUM_PORTS];
    logic                 fair_en;
    // Set once a port has seen waitrequest while holding a command
    logic [NUM_PORTS-1:0] saw_wait;

    int chk_errors;
    int chk_checked;
    int chk_pending;
    int chk_accepted;
    int chk_completed;
    int tb_errors;
    int err_mark;
    int tests_run;
    int tests_bad;
    int acc_start;
    int done_start;

    always #20 clk = ~clk;

    avmm_mux_top i_dut
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .waitrequest (waitrequest),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

    avmm_mux_checker i_checker
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .waitrequest (waitrequest),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .fair_en     (fair_en),
        .errors      (chk_errors),
        .checked     (chk_checked),
        .pending     (chk_pending),
        .accepted    (chk_accepted),
        .completed   (chk_completed)
    );

    // ==================================================
    // Stimulus helpers
    // ==================================================

    task automatic abort_run();
        $display("tests failed");
        $finish;
    endtask

    function automatic avmm_req_t make_cmd(input avmm_op_e op, input addr_t addr,
                                           input int beats, input byte_en_t be,
                                           input data_t data);
        avmm_req_t c;
        c.op         = op;
        c.addr       = addr;
        c.burstcount = burst_t'(beats);
        c.byteenable = be;
        c.writedata  = data;
        return c;
    endfunction

    // A burst never leaves the port's own window
    function automatic avmm_req_t rand_cmd(input int p, input bit long_read);
        avmm_op_e op;
        int       beats;
        op    = (long_read || $urandom_range(1, 0) == 0) ? OP_READ : OP_WRITE;
        beats = long_read ? 4 : ((op == OP_READ) ? $urandom_range(4, 1) : 1);
        return make_cmd(op, addr_t'(16 * p + $urandom_range(16 - beats, 0)), beats,
                        byte_en_t'($urandom), $urandom);
    endfunction

    // Called on a rising edge; returns on the edge that accepts the command
    task automatic send_cmd(input int p, input avmm_req_t cmd);
        int waited;
        waited = 0;
        req_valid[p] <= 1'b1;
        req[p]       <= cmd;
        @(posedge clk);
        while (waitrequest[p])
        begin
            saw_wait[p] = 1'b1;
            waited++;
            if (waited > ACCEPT_TIMEOUT)
            begin
                $display("Port %0d command was not accepted within %0d cycles", p, waited);
                abort_run();
            end
            @(posedge clk);
        end
    endtask

    task automatic run_port(input int p, input int n, input int max_gap, input bit long_read);
        int gap;
        for (int i = 0; i < n; i++)
        begin
            send_cmd(p, rand_cmd(p, long_read));
            gap = $urandom_range(max_gap, 0);
            if (gap > 0)
            begin
                req_valid[p] <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        req_valid[p] <= 1'b0;
    endtask

    // Wait until every expected response has come back
    task automatic wait_drain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (chk_pending != 0)
        begin
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
            begin
                $display("%0d responses still missing after %0d cycles", chk_pending, cycles);
                abort_run();
            end
            @(negedge clk);
        end
    endtask

    task automatic expect_low(input string name, input logic [NUM_PORTS-1:0] act);
        if (act !== '0)
        begin
            tb_errors++;
            $display("ERROR t=%0t %s expected %b actual %b", $time, name, 3'b000, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act)
        begin
            tb_errors++;
            $display("ERROR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input int num, input string name);
        int now_err;
        now_err = tb_errors + chk_errors;
        tests_run++;
        if (now_err != err_mark)
        begin
            tests_bad++;
            $display("test %0d %s: FAILED with %0d errors", num, name, now_err - err_mark);
        end
        else
        begin
            $display("test %0d %s: ok", num, name);
        end
        err_mark = now_err;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        void'($urandom(32'h642c));
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = '0;
        fair_en   = 1'b0;
        saw_wait  = '0;
        for (int p = 0; p < NUM_PORTS; p++)
            req[p] = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // Idle outputs, then a read of a word nobody wrote
        @(negedge clk);
        expect_low("waitrequest", waitrequest);
        expect_low("rsp_valid", rsp_valid);
        @(posedge clk);
        send_cmd(0, make_cmd(OP_READ, 6'd5, 1, 4'hf, '0));
        req_valid[0] <= 1'b0;
        wait_drain();
        end_test(1, "reset state");

        // Partial enables merge into words 16 to 18, then one 4-beat read
        @(posedge clk);
        send_cmd(1, make_cmd(OP_WRITE, 6'd16, 1, 4'b1111, 32'h1122_3344));
        send_cmd(1, make_cmd(OP_WRITE, 6'd16, 1, 4'b0101, 32'haabb_ccdd));
        send_cmd(1, make_cmd(OP_WRITE, 6'd17, 1, 4'b1100, 32'h5566_7788));
        send_cmd(1, make_cmd(OP_WRITE, 6'd18, 1, 4'b0011, 32'h99aa_bbcc));
        send_cmd(1, make_cmd(OP_READ, 6'd16, 4, 4'b1111, '0));
        req_valid[1] <= 1'b0;
        wait_drain();
        end_test(2, "byte enables and burst read");

        @(posedge clk);
        fork
            run_port(0, 30, 2, 1'b0);
            run_port(1, 30, 2, 1'b0);
            run_port(2, 30, 2, 1'b0);
        join
        wait_drain();
        end_test(3, "random traffic on all ports");

        // One port saturating the memory with long reads
        acc_start  = chk_accepted;
        done_start = chk_completed;
        saw_wait   = '0;
        @(posedge clk);
        run_port(2, 12, 0, 1'b1);
        wait_drain();
        if (!saw_wait[2])
        begin
            tb_errors++;
            $display("waitrequest on port 2 never rose under back-pressure");
        end
        check_count("completed commands", chk_accepted - acc_start,
                    chk_completed - done_start);
        end_test(4, "back-pressure");

        // The checker compares completion counts while fair_en is high
        @(posedge clk);
        fair_en <= 1'b1;
        fork
            run_port(0, 16, 0, 1'b0);
            run_port(1, 16, 0, 1'b0);
            run_port(2, 16, 0, 1'b0);
        join
        wait_drain();
        @(posedge clk);
        fair_en <= 1'b0;
        end_test(5, "fairness under saturation");

        $display("tests run %0d, failing %0d, errors %0d, responses checked %0d, missing %0d",
                 tests_run, tests_bad, tb_errors + chk_errors, chk_checked, chk_pending);
        if (tests_bad == 0 && tb_errors + chk_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/avmm_bus_pkg.sv
/*
 * Bus-level types shared by the request ports and the memory model.
 * Addresses are word addresses; the memory is 64 words of 32 bits.
 * Writes are single-beat only; read bursts run 1 to 4 beats.
 */
`default_nettype none

package avmm_bus_pkg;

    // ==================================================
    // Memory sizing
    // ==================================================

    localparam int MEM_WORDS   = 64;
    // Cycles from issue of a beat to its response at the memory output
    localparam int MEM_LATENCY = 2;

    // ==================================================
    // Field types
    // ==================================================

    typedef logic [5:0]  addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_en_t;
    // Beat count, legal range 1 to 4
    typedef logic [2:0]  burst_t;

    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } avmm_op_e;

    // ==================================================
    // Command and response words
    // ==================================================

    // One command as presented by a port; burstcount is 1 for a write
    typedef struct packed
    {
        avmm_op_e op;
        addr_t    addr;
        burst_t   burstcount;
        byte_en_t byteenable;
        data_t    writedata;
    } avmm_req_t;

    // One response beat; last marks the final beat of a command
    typedef struct packed
    {
        avmm_op_e op;
        data_t    readdata;
        logic     last;
    } avmm_rsp_t;

endpackage

`default_nettype wire

//--- verilog/avmm_cmd_fifo.sv
/*
 * Two-entry command buffer with push and pop in the same cycle.
 * The caller must not push while full is high.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_cmd_fifo
    import avmm_bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      push,
    input  avmm_req_t push_data,
    output logic      full,
    input  logic      pop,
    output avmm_req_t head,
    output logic      not_empty
);

    // Slot 0 is always the head, slot 1 the entry behind it
    avmm_req_t  slot [2];
    logic [1:0] count;

    assign head      = slot[0];
    assign full      = (count == 2'd2);
    assign not_empty = (count != 2'd0);

    // Occupancy count
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            count <= 2'd0;
        end
        else if (push && !pop)
        begin
            count <= count + 2'd1;
        end
        else if (pop && !push)
        begin
            count <= count - 2'd1;
        end
    end

    // Entries move toward slot 0 on a pop
    always_ff @(posedge clk)
    begin
        if (pop)
        begin
            // With two entries the second moves up, otherwise a new push lands on the head
            slot[0] <= (count == 2'd2) ? slot[1] : push_data;
            slot[1] <= push_data;
        end
        else if (push)
        begin
            if (count == 2'd0)
                slot[0] <= push_data;
            else
                slot[1] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/avmm_mem_model.sv
/*
 * Pipelined on-chip memory; every beat answers MEM_LATENCY cycles after issue.
 * Read bursts wrap at the top of memory. A write is a single beat whatever its
 * burstcount. The array clears to zero on reset.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_mem_model
    import avmm_bus_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      mem_valid,
    input  avmm_req_t mem_req,
    output logic      mem_wait,
    output logic      mem_rsp_valid,
    output avmm_rsp_t mem_rsp
);

    typedef enum logic
    {
        MEM_IDLE,
        MEM_BURST
    } mem_state_e;

    mem_state_e state;
    data_t      mem [MEM_WORDS];

    // Remaining read beats after the first, and where the next one reads
    addr_t      burst_addr;
    burst_t     burst_left;

    // The beat presented to the array in this cycle
    logic       beat_valid;
    addr_t      beat_addr;
    avmm_rsp_t  beat_rsp;
    logic       new_burst;

    // Response pipeline, one stage per cycle of latency
    logic       pipe_valid [MEM_LATENCY];
    avmm_rsp_t  pipe_rsp   [MEM_LATENCY];

    // ==================================================
    // Beat issue
    // ==================================================

    assign mem_wait  = (state == MEM_BURST);
    assign new_burst = (state == MEM_IDLE) && mem_valid && (mem_req.op == OP_READ) &&
                       (mem_req.burstcount > burst_t'(1));

    always_comb
    begin
        beat_valid = mem_valid || (state == MEM_BURST);
        beat_addr  = (state == MEM_BURST) ? burst_addr : mem_req.addr;
        if (state == MEM_BURST)
        begin
            beat_rsp.op       = OP_READ;
            beat_rsp.readdata = mem[beat_addr];
            beat_rsp.last     = (burst_left == burst_t'(1));
        end
        else
        begin
            beat_rsp.op       = mem_req.op;
            beat_rsp.readdata = (mem_req.op == OP_READ) ? mem[beat_addr] : '0;
            beat_rsp.last     = !new_burst;
        end
    end

    // Burst FSM; mem_wait covers the beats after the first
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= MEM_IDLE;
            burst_addr <= '0;
            burst_left <= '0;
        end
        else if (new_burst)
        begin
            state      <= MEM_BURST;
            burst_addr <= mem_req.addr + 1'b1;
            burst_left <= mem_req.burstcount - burst_t'(1);
        end
        else if (state == MEM_BURST)
        begin
            // Address wraps naturally at MEM_WORDS
            burst_addr <= burst_addr + 1'b1;
            burst_left <= burst_left - burst_t'(1);
            if (burst_left == burst_t'(1))
                state <= MEM_IDLE;
        end
    end

    // Writes merge the enabled bytes at issue
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end
        else if ((state == MEM_IDLE) && mem_valid && (mem_req.op == OP_WRITE))
        begin
            for (int b = 0; b < $bits(byte_en_t); b++)
            begin
                if (mem_req.byteenable[b])
                    mem[mem_req.addr][8*b +: 8] <= mem_req.writedata[8*b +: 8];
            end
        end
    end

    // ==================================================
    // Response pipeline
    // ==================================================

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int s = 0; s < MEM_LATENCY; s++)
                pipe_valid[s] <= 1'b0;
        end
        else
        begin
            pipe_valid[0] <= beat_valid;
            for (int s = 1; s < MEM_LATENCY; s++)
                pipe_valid[s] <= pipe_valid[s-1];
        end
    end

    always_ff @(posedge clk)
    begin
        pipe_rsp[0] <= beat_rsp;
        for (int s = 1; s < MEM_LATENCY; s++)
            pipe_rsp[s] <= pipe_rsp[s-1];
    end

    assign mem_rsp_valid = pipe_valid[MEM_LATENCY-1];
    assign mem_rsp       = pipe_rsp[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/avmm_mux_pkg.sv
/*
 * Sizing of the port multiplexer and the tracker entry format.
 * The port count is fixed here and is not a module parameter.
 */
`default_nettype none

package avmm_mux_pkg;

    import avmm_bus_pkg::*;

    // Number of request ports sharing the memory
    localparam int NUM_PORTS   = 3;
    // Commands that may be outstanding at the memory at once
    localparam int TRACK_DEPTH = 4;

    // Wide enough to name every port
    typedef logic [1:0] port_idx_t;

    // What the response router needs to know about each issued command
    typedef struct packed
    {
        port_idx_t port;
        avmm_op_e  op;
        burst_t    burstcount;
    } track_entry_t;

endpackage

`default_nettype wire

//--- verilog/avmm_mux_top.sv
/*
 * Shares one pipelined memory among NUM_PORTS command ports.
 * Responses per port come back in that port's command order, with no
 * back-pressure on the response side. waitrequest may rise without valid.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_mux_top
    import avmm_bus_pkg::*;
    import avmm_mux_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [NUM_PORTS-1:0] req_valid,
    input  avmm_req_t            req [NUM_PORTS],
    output logic [NUM_PORTS-1:0] waitrequest,
    output logic [NUM_PORTS-1:0] rsp_valid,
    output avmm_rsp_t            rsp [NUM_PORTS]
);

    // ==================================================
    // Producer side, per-port buffers and arbitration
    // ==================================================

    logic [NUM_PORTS-1:0] buf_full;
    logic [NUM_PORTS-1:0] buf_not_empty;
    logic [NUM_PORTS-1:0] grant;
    avmm_req_t            buf_head [NUM_PORTS];
    port_idx_t            grant_idx;

    logic                 mem_valid;
    logic                 mem_wait;
    avmm_req_t            mem_req;
    logic                 mem_rsp_valid;
    avmm_rsp_t            mem_rsp;
    logic                 track_full;

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_buf
        // A command is taken on any edge where the buffer has room
        avmm_cmd_fifo i_cmd_fifo
        (
            .clk       (clk),
            .arst_n    (arst_n),
            .push      (req_valid[p] && !buf_full[p]),
            .push_data (req[p]),
            .full      (buf_full[p]),
            .pop       (grant[p]),
            .head      (buf_head[p]),
            .not_empty (buf_not_empty[p])
        );
    end

    assign waitrequest = buf_full;

    // Arbitrate only when both the memory and the tracker can take a command
    avmm_rr_arbiter i_arbiter
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (!mem_wait && !track_full),
        .request   (buf_not_empty),
        .grant     (grant),
        .grant_idx (grant_idx)
    );

    assign mem_valid = |grant;
    assign mem_req   = buf_head[grant_idx];

    // ==================================================
    // Consumer and response tracking
    // ==================================================

    avmm_mem_model i_mem
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_valid     (mem_valid),
        .mem_req       (mem_req),
        .mem_wait      (mem_wait),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp)
    );

    avmm_rsp_router i_router
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue          (mem_valid),
        .issue_port     (grant_idx),
        .issue_req      (mem_req),
        .full           (track_full),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .port_rsp_valid (rsp_valid),
        .port_rsp       (rsp)
    );

endmodule

`default_nettype wire

//--- verilog/avmm_rr_arbiter.sv
/*
 * Round-robin arbiter; the grant is combinational in the request cycle.
 * Nobody is granted while enable is low. A grant is taken whenever shown.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_rr_arbiter
    import avmm_bus_pkg::*;
    import avmm_mux_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 enable,
    input  logic [NUM_PORTS-1:0] request,
    output logic [NUM_PORTS-1:0] grant,
    output port_idx_t            grant_idx
);

    // Port with the highest priority in this cycle
    port_idx_t ptr;
    // Ports in priority order, starting at the pointer
    port_idx_t order [NUM_PORTS];

    always_comb
    begin
        for (int i = 0; i < NUM_PORTS; i++)
        begin
            order[i] = port_idx_t'((int'(ptr) + i) % NUM_PORTS);
        end
    end

    // Walk from the lowest priority up so the highest-priority requester wins last
    always_comb
    begin
        grant     = '0;
        grant_idx = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--)
        begin
            if (enable && request[order[i]])
            begin
                grant            = '0;
                grant[order[i]]  = 1'b1;
                grant_idx        = order[i];
            end
        end
    end

    // The winner drops to the lowest priority once its grant is taken
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ptr <= '0;
        end
        else if (|grant)
        begin
            ptr <= (grant_idx == port_idx_t'(NUM_PORTS - 1)) ? '0 : grant_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/avmm_rsp_router.sv
/*
 * Tracks issued commands in order and steers memory responses to ports.
 * Relies on the memory answering strictly in issue order.
 * The issuer must hold off while full is high.
 */
`timescale 1ns/1ps
`default_nettype none

module avmm_rsp_router
    import avmm_bus_pkg::*;
    import avmm_mux_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 issue,
    input  port_idx_t            issue_port,
    input  avmm_req_t            issue_req,
    output logic                 full,
    input  logic                 mem_rsp_valid,
    input  avmm_rsp_t            mem_rsp,
    output logic [NUM_PORTS-1:0] port_rsp_valid,
    output avmm_rsp_t            port_rsp [NUM_PORTS]
);

    // ==================================================
    // Tracker FIFO
    // ==================================================

    track_entry_t                   track_q [TRACK_DEPTH];
    logic [$clog2(TRACK_DEPTH)-1:0] wr_ptr;
    logic [$clog2(TRACK_DEPTH)-1:0] rd_ptr;
    logic [$clog2(TRACK_DEPTH):0]   count;
    track_entry_t                   head;
    track_entry_t                   new_entry;

    // Beat number within the head command, counting from 1
    burst_t beat_num;
    // The current response beat finishes the head command
    logic   beat_done;

    assign head      = track_q[rd_ptr];
    assign full      = (count == TRACK_DEPTH);
    assign beat_done = mem_rsp_valid && (beat_num == head.burstcount);

    always_comb
    begin
        new_entry.port       = issue_port;
        new_entry.op         = issue_req.op;
        new_entry.burstcount = issue_req.burstcount;
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            track_q[wr_ptr] <= new_entry;
    end

    // Pointers and occupancy; an entry leaves on its final beat
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            beat_num <= burst_t'(1);
        end
        else
        begin
            if (issue)
                wr_ptr <= wr_ptr + 1'b1;
            if (beat_done)
                rd_ptr <= rd_ptr + 1'b1;
            if (issue && !beat_done)
                count <= count + 1'b1;
            else if (beat_done && !issue)
                count <= count - 1'b1;

            if (beat_done)
                beat_num <= burst_t'(1);
            else if (mem_rsp_valid)
                beat_num <= beat_num + burst_t'(1);
        end
    end

    // ==================================================
    // Registered per-port response outputs
    // ==================================================

    for (genvar p = 0; p < NUM_PORTS; p++)
    begin : g_port
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
                port_rsp_valid[p] <= 1'b0;
            else
                port_rsp_valid[p] <= mem_rsp_valid && (head.port == port_idx_t'(p));
        end

        // Every port sees the same payload, only the valid is steered
        always_ff @(posedge clk)
        begin
            port_rsp[p].op       <= head.op;
            port_rsp[p].readdata <= mem_rsp.readdata;
            port_rsp[p].last     <= beat_done;
        end
    end

endmodule

`default_nettype wire
